//--- list.f
source/ex_pkg.sv
source/instr_queue.sv
source/reg_file.sv
source/alu_decode.sv
source/alu.sv
source/branch_unit.sv
source/ex_stage.sv
source/exec_top.sv
test/exec_assertions.sv
test/exec_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exec_tb -f list.f

out=$(./obj_dir/Vexec_tb) || true
printf '%s\n' "$out"

# pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'sim passed'

//--- source/alu.sv
`timescale 1ns/1ns

module alu import ex_pkg::*; (
	input alu_op_t alu_op,
	input logic [data_w-1:0] a,
	input logic [data_w-1:0] b,
	output logic [data_w-1:0] y
);

	logic [4:0] shamt;
	logic lt;

	assign shamt = b[4:0];
	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (alu_op)
			alu_add: begin
				y = a + b;
			end
			alu_sub: begin
				y = a - b;
			end
			alu_and: begin
				y = a & b;
			end
			alu_or: begin
				y = a | b;
			end
			alu_xor: begin
				y = a ^ b;
			end
			alu_sll: begin
				y = a << shamt;
			end
			alu_srl: begin
				y = a >> shamt; // logical, zero fill
			end
			alu_slt: begin
				y = {{(data_w - 1){1'b0}}, lt};
			end
			alu_pass_b: begin
				y = b;
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

//--- source/alu_decode.sv
`timescale 1ns/1ns

module alu_decode import ex_pkg::*; (
	input opcode_t opcode,
	output alu_op_t alu_op,
	output logic use_imm,
	output logic is_beq,
	output logic is_bne,
	output logic is_jr,
	output logic writes_rd
);

	always_comb begin
		alu_op = alu_add;
		use_imm = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_jr = 1'b0;
		writes_rd = 1'b1;
		case (opcode)
			op_add: alu_op = alu_add;
			op_sub: alu_op = alu_sub;
			op_and: alu_op = alu_and;
			op_or: alu_op = alu_or;
			op_xor: alu_op = alu_xor;
			op_sll: alu_op = alu_sll;
			op_srl: alu_op = alu_srl;
			op_slt: alu_op = alu_slt;
			op_addi: begin
				alu_op = alu_add;
				use_imm = 1'b1;
			end
			op_lui: begin
				alu_op = alu_pass_b; // immediate arrives already shifted up
				use_imm = 1'b1;
			end
			op_beq: begin
				alu_op = alu_sub;
				is_beq = 1'b1;
				writes_rd = 1'b0;
			end
			op_bne: begin
				alu_op = alu_sub;
				is_bne = 1'b1;
				writes_rd = 1'b0;
			end
			op_jr: begin
				alu_op = alu_pass_b;
				is_jr = 1'b1;
				writes_rd = 1'b0;
			end
			default: writes_rd = 1'b0;
		endcase
	end

endmodule

//--- source/branch_unit.sv
`timescale 1ns/1ns

module branch_unit import ex_pkg::*; (
	input logic [data_w-1:0] op_a,
	input logic [data_w-1:0] op_b,
	input logic [data_w-1:0] pc,
	input logic [data_w-1:0] imm,
	input logic [data_w-1:0] pfc,
	input logic predicted,
	input logic is_beq,
	input logic is_bne,
	input logic is_jr,
	output logic mispredict,
	output logic [data_w-1:0] redirect_pc
);

	logic is_equal;
	logic taken;

	assign is_equal = (op_a == op_b);
	assign taken = is_beq ? is_equal : !is_equal; // only meaningful for bne otherwise

	always_comb begin
		mispredict = 1'b0;
		redirect_pc = pc + 1'b1; // pc counts words
		if (is_jr) begin
			redirect_pc = op_a;
			mispredict = (op_a != pfc);
		end else if (is_beq || is_bne) begin
			mispredict = (taken != predicted);
			if (taken) begin
				redirect_pc = pc + imm;
			end
		end
	end

endmodule

//--- source/ex_pkg.sv
package ex_pkg;

	localparam int data_w = 32;
	localparam int reg_idx_w = 5;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_sll,
		op_srl,
		op_slt,
		op_addi,
		op_lui,
		op_beq,
		op_bne,
		op_jr
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	typedef struct packed {
		opcode_t opcode;
		logic [reg_idx_w-1:0] rd;
		logic [reg_idx_w-1:0] rs1;
		logic [reg_idx_w-1:0] rs2;
		logic [data_w-1:0] imm;
		logic [data_w-1:0] pc;
		logic [data_w-1:0] pfc; // predicted next pc
		logic predicted; // predicted taken
	} instr_t;

	typedef struct packed {
		instr_t instr;
		logic [data_w-1:0] rs1_val;
		logic [data_w-1:0] rs2_val;
	} issued_t;

	typedef struct packed {
		logic [data_w-1:0] pc;
		logic [reg_idx_w-1:0] rd;
		logic [data_w-1:0] value;
		logic wr_en;
		logic is_ctrl;
		logic mispredict;
		logic [data_w-1:0] redirect_pc;
	} result_t;

endpackage

//--- source/ex_stage.sv
`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input issued_t issued,
	output logic wr_en,
	output logic [reg_idx_w-1:0] wr_idx,
	output logic [data_w-1:0] wr_data,
	output logic res_valid,
	output result_t res
);

	issued_t op_q; // operand register
	result_t res_q; // result register
	result_t ret_q; // retire register
	logic op_valid;
	logic res_q_valid;
	logic ret_valid;

	alu_op_t alu_op;
	logic use_imm;
	logic is_beq;
	logic is_bne;
	logic is_jr;
	logic writes_rd;
	logic [data_w-1:0] fwd_a;
	logic [data_w-1:0] fwd_b;
	logic [data_w-1:0] imm_val;
	logic [data_w-1:0] alu_b;
	logic [data_w-1:0] alu_y;
	logic mispredict;
	logic [data_w-1:0] redirect_pc;
	result_t res_d;

	function automatic logic hits(input logic v, input result_t r, input logic [reg_idx_w-1:0] idx);
		return v && r.wr_en && (r.rd != '0) && (r.rd == idx);
	endfunction

	// youngest producer wins
	assign fwd_a = hits(res_q_valid, res_q, op_q.instr.rs1) ? res_q.value :
		hits(ret_valid, ret_q, op_q.instr.rs1) ? ret_q.value : op_q.rs1_val;
	assign fwd_b = hits(res_q_valid, res_q, op_q.instr.rs2) ? res_q.value :
		hits(ret_valid, ret_q, op_q.instr.rs2) ? ret_q.value : op_q.rs2_val;

	assign imm_val = (op_q.instr.opcode == op_lui) ? {op_q.instr.imm[15:0], 16'b0} :
		op_q.instr.imm;
	assign alu_b = use_imm ? imm_val : fwd_b;

	alu_decode alu_decode_inst (.opcode(op_q.instr.opcode), .alu_op(alu_op), .use_imm(use_imm),
		.is_beq(is_beq), .is_bne(is_bne), .is_jr(is_jr), .writes_rd(writes_rd));

	alu alu_inst (.alu_op(alu_op), .a(fwd_a), .b(alu_b), .y(alu_y));

	branch_unit branch_unit_inst (.op_a(fwd_a), .op_b(fwd_b), .pc(op_q.instr.pc),
		.imm(op_q.instr.imm), .pfc(op_q.instr.pfc), .predicted(op_q.instr.predicted),
		.is_beq(is_beq), .is_bne(is_bne), .is_jr(is_jr), .mispredict(mispredict),
		.redirect_pc(redirect_pc));

	always_comb begin
		res_d.pc = op_q.instr.pc;
		res_d.rd = op_q.instr.rd;
		res_d.value = alu_y;
		res_d.wr_en = writes_rd && (op_q.instr.rd != '0);
		res_d.is_ctrl = is_beq || is_bne || is_jr;
		res_d.mispredict = mispredict;
		res_d.redirect_pc = redirect_pc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid <= 1'b0;
			res_q_valid <= 1'b0;
			ret_valid <= 1'b0;
		end else begin
			op_valid <= issue_valid;
			res_q_valid <= op_valid;
			ret_valid <= res_q_valid;
		end
	end

	always_ff @(posedge clk) begin
		op_q <= issued;
		res_q <= res_d;
		ret_q <= res_q;
	end

	assign wr_en = ret_valid && ret_q.wr_en;
	assign wr_idx = ret_q.rd;
	assign wr_data = ret_q.value;
	assign res_valid = ret_valid;
	assign res = ret_q;

endmodule

//--- source/exec_top.sv
`timescale 1ns/1ns

module exec_top import ex_pkg::*; #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input instr_t in_instr,
	output logic credit_return,
	output logic res_valid,
	output result_t res
);

	logic issue_valid;
	instr_t issue_instr;
	logic [data_w-1:0] rs1_val;
	logic [data_w-1:0] rs2_val;
	logic wr_en;
	logic [reg_idx_w-1:0] wr_idx;
	logic [data_w-1:0] wr_data;
	issued_t issued;

	// head entry joined with its register reads
	assign issued.instr = issue_instr;
	assign issued.rs1_val = rs1_val;
	assign issued.rs2_val = rs2_val;

	instr_queue #(.queue_depth(queue_depth)) instr_queue_inst (.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_instr(in_instr), .issue_valid(issue_valid),
		.issue_instr(issue_instr), .credit_return(credit_return));

	reg_file reg_file_inst (.clk(clk), .reset(reset), .rs1(issue_instr.rs1),
		.rs2(issue_instr.rs2), .rs1_val(rs1_val), .rs2_val(rs2_val), .wr_en(wr_en),
		.wr_idx(wr_idx), .wr_data(wr_data));

	ex_stage ex_stage_inst (.clk(clk), .reset(reset), .issue_valid(issue_valid),
		.issued(issued), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
		.res_valid(res_valid), .res(res));

endmodule

//--- source/instr_queue.sv
`timescale 1ns/1ns

module instr_queue import ex_pkg::*; #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input instr_t in_instr,
	output logic issue_valid,
	output instr_t issue_instr,
	output logic credit_return
);

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);

	instr_t mem [queue_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic full;
	logic push;
	logic pop;

	// wraps for any depth, not only powers of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == cnt_w'(queue_depth));
	assign push = in_valid && !full; // a push into a full queue is lost
	assign pop = (count != '0); // head leaves every cycle it exists

	assign issue_valid = pop;
	assign issue_instr = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_instr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + cnt_w'(push) - cnt_w'(pop);
			credit_return <= pop; // one credit per freed entry
		end
	end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns

module reg_file import ex_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [reg_idx_w-1:0] rs1,
	input logic [reg_idx_w-1:0] rs2,
	output logic [data_w-1:0] rs1_val,
	output logic [data_w-1:0] rs2_val,
	input logic wr_en,
	input logic [reg_idx_w-1:0] wr_idx,
	input logic [data_w-1:0] wr_data
);

	logic [data_w-1:0] regs [2**reg_idx_w];
	logic wr_live;

	assign wr_live = wr_en && (wr_idx != '0); // r0 is never written

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**reg_idx_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// write-through so a reader in the write cycle sees the new value
	assign rs1_val = (wr_live && wr_idx == rs1) ? wr_data : regs[rs1];
	assign rs2_val = (wr_live && wr_idx == rs2) ? wr_data : regs[rs2];

endmodule

//--- test/exec_assertions.sv
`timescale 1ns/1ns

module exec_assertions #(
	parameter int queue_depth = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic full,
	input logic [$clog2(queue_depth + 1)-1:0] count,
	input logic credit_return,
	input logic res_valid
);

	int held; // pushes not yet answered by a credit

	always_ff @(posedge clk) begin
		if (reset) begin
			held <= 0;
		end else begin
			held <= held + int'(in_valid) - int'(credit_return);
		end
	end

	// an entry leaves the count one cycle before its credit shows up
	count_bound: assert property (@(posedge clk) disable iff (reset)
		held <= queue_depth && int'(count) + int'(credit_return) == held)
		else $error("queue holds %0d entries with %0d pushes outstanding", count, held);

	// the front end must hold a credit for every push
	no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		!(in_valid && full))
		else $error("push arrived while the queue was full");

	res_valid_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(res_valid))
		else $error("res_valid is unknown");

endmodule

//--- test/exec_tb.sv
`timescale 1ns/1ns

module exec_tb import ex_pkg::*; ();

	localparam int queue_depth = 4;
	localparam int n_alu = 52;
	localparam int n_imm = 30;
	localparam int n_chain = 48;
	localparam int n_branch = 30;
	localparam int n_jump = 30;
	localparam int n_credit = 60;
	localparam int n_total = n_alu + n_imm + n_chain + n_branch + n_jump + n_credit;
	localparam int cycle_limit = 20 * n_total + 100;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	instr_t in_instr;
	logic credit_return;
	logic res_valid;
	result_t res;

	logic [data_w-1:0] model_regs [32]; // architectural register state
	result_t exp_q[$];
	logic [reg_idx_w-1:0] hist [3]; // rd of the last three instructions, youngest first
	logic [data_w-1:0] next_pc;
	int credits;
	int credit_pulses;
	int errors;
	int checks;
	int cycles;
	int burst_left;
	int gap_left;

	exec_top #(.queue_depth(queue_depth)) exec_top_inst (.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_instr(in_instr), .credit_return(credit_return),
		.res_valid(res_valid), .res(res));

	bind exec_top exec_assertions #(.queue_depth(queue_depth)) exec_assertions_inst (
		.clk(clk), .reset(reset), .in_valid(in_valid), .full(instr_queue_inst.full),
		.count(instr_queue_inst.count), .credit_return(credit_return),
		.res_valid(res_valid));

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	function automatic logic [reg_idx_w-1:0] rand_reg(input bit allow_zero);
		return reg_idx_w'($urandom_range(31, allow_zero ? 0 : 1));
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERROR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_result(input result_t got, input result_t exp);
		compare_field("res.pc", got.pc, exp.pc);
		compare_field("res.rd", 32'(got.rd), 32'(exp.rd));
		compare_field("res.wr_en", 32'(got.wr_en), 32'(exp.wr_en));
		compare_field("res.is_ctrl", 32'(got.is_ctrl), 32'(exp.is_ctrl));
		compare_field("res.mispredict", 32'(got.mispredict), 32'(exp.mispredict));
		if (exp.is_ctrl) begin
			compare_field("res.redirect_pc", got.redirect_pc, exp.redirect_pc);
		end else begin
			compare_field("res.value", got.value, exp.value);
		end
	endtask

	// in-order reference execution
	task automatic run_model(input instr_t ins, output result_t r);
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] v;
		logic taken;
		logic ctrl;
		a = model_regs[ins.rs1];
		b = model_regs[ins.rs2];
		v = '0;
		r = '0;
		r.pc = ins.pc;
		r.rd = ins.rd;
		r.redirect_pc = ins.pc + 32'd1;
		ctrl = ins.opcode inside {op_beq, op_bne, op_jr};
		case (ins.opcode)
			op_add: v = a + b;
			op_sub: v = a - b;
			op_and: v = a & b;
			op_or: v = a | b;
			op_xor: v = a ^ b;
			op_sll: v = a << b[4:0];
			op_srl: v = a >> b[4:0];
			op_slt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			op_addi: v = a + ins.imm;
			op_lui: v = {ins.imm[15:0], 16'h0000};
			op_beq, op_bne: begin
				taken = (a == b) ^ (ins.opcode == op_bne);
				r.mispredict = (taken != ins.predicted);
				if (taken) begin
					r.redirect_pc = ins.pc + ins.imm;
				end
			end
			op_jr: begin
				r.redirect_pc = a;
				r.mispredict = (a != ins.pfc);
			end
			default: ;
		endcase
		r.value = v;
		r.is_ctrl = ctrl;
		r.wr_en = !ctrl && (ins.rd != '0);
		if (r.wr_en) begin
			model_regs[ins.rd] = v;
		end
	endtask

	task automatic make_instr(input int test_id, input int idx, output instr_t ins);
		ins = '0;
		ins.pc = next_pc;
		ins.rd = rand_reg(1'b1);
		ins.rs1 = rand_reg(1'b1);
		ins.rs2 = rand_reg(1'b1);
		ins.imm = $urandom;
		ins.pfc = next_pc + 32'd1;
		ins.predicted = 1'($urandom);
		case (test_id)
			1: begin
				ins.opcode = opcode_t'(4'($urandom_range(7, 0)));
				if (idx < 12) begin
					ins.opcode = op_addi; // registers still hold their reset zeros
					ins.rd = rand_reg(1'b0);
					ins.rs1 = '0;
				end
			end
			2: begin
				ins.opcode = ($urandom_range(1, 0) == 0) ? op_addi : op_lui;
				if ($urandom_range(3, 0) == 0) ins.rd = '0;
				if ($urandom_range(1, 0) == 0) ins.rs1 = '0;
			end
			3: begin
				ins.opcode = opcode_t'(4'($urandom_range(8, 0)));
				ins.rd = rand_reg(1'b0);
				ins.rs1 = hist[2'($urandom_range(2, 0))]; // 1, 2 or 3 back
				ins.rs2 = hist[2'($urandom_range(2, 0))];
				ins.imm = $urandom_range(255, 0);
			end
			4: begin
				ins.opcode = ($urandom_range(1, 0) == 0) ? op_beq : op_bne;
				if ($urandom_range(1, 0) == 0) ins.rs2 = ins.rs1;
				ins.imm = $urandom_range(64, 0) - 32'd32;
			end
			5: begin
				if (idx % 2 == 0) begin
					ins.opcode = op_addi; // fresh target for the next jr
					ins.rd = rand_reg(1'b0);
				end else begin
					ins.opcode = op_jr;
					ins.rs1 = hist[0];
					if ($urandom_range(1, 0) == 0) ins.pfc = model_regs[hist[0]];
					else ins.pfc = $urandom;
				end
			end
			default: ins.opcode = opcode_t'(4'($urandom_range(9, 0)));
		endcase
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = ins.rd;
		next_pc = next_pc + 32'd1;
	endtask

	task automatic observe();
		result_t expected;
		if (credit_return) begin
			credits++;
			credit_pulses++;
		end
		if (res_valid) begin
			assert (exp_q.size() != 0) else begin
				$display("result for pc %h arrived with no instruction outstanding", res.pc);
				errors++;
			end
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				check_result(res, expected);
			end
		end
	endtask

	// a negative percentage selects bursts at full rate with random gaps
	task automatic decide_send(input int send_pct, output bit ok);
		if (send_pct >= 0) begin
			ok = ($urandom_range(99, 0) < send_pct);
		end else begin
			if (burst_left == 0 && gap_left == 0) begin
				burst_left = $urandom_range(8, 2);
				gap_left = $urandom_range(5, 1);
			end
			if (burst_left > 0) begin
				ok = 1'b1;
				burst_left--;
			end else begin
				ok = 1'b0;
				gap_left--;
			end
		end
	endtask

	task automatic run_test(input int test_id, input string name, input int count,
		input int send_pct);
		int left;
		int err_before;
		int pulses_before;
		bit ok;
		instr_t ins;
		result_t r;
		left = count;
		err_before = errors;
		pulses_before = credit_pulses;
		while (left > 0 || exp_q.size() != 0) begin
			@(negedge clk);
			observe();
			in_valid = 1'b0;
			ok = 1'b0;
			if (left > 0 && credits > 0) decide_send(send_pct, ok);
			if (ok) begin
				make_instr(test_id, count - left, ins);
				run_model(ins, r);
				exp_q.push_back(r);
				in_instr = ins;
				in_valid = 1'b1;
				credits--;
				left--;
			end
		end
		assert (credit_pulses - pulses_before == count) else begin
			$display("ERROR credit_return pulses: got %h expected %h",
				credit_pulses - pulses_before, count);
			errors++;
		end
		assert (credits == queue_depth) else begin
			$display("ERROR credit counter: got %h expected %h", credits, queue_depth);
			errors++;
		end
		$display("test %0d %s: %0d sent, %0d errors", test_id, name, count,
			errors - err_before);
	endtask

	initial begin
		void'($urandom(32'h7f66_4a4a));
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		credits = queue_depth;
		credit_pulses = 0;
		burst_left = 0;
		gap_left = 0;
		next_pc = 32'h0000_0100;
		hist[0] = 5'd1;
		hist[1] = 5'd2;
		hist[2] = 5'd3;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;
		run_test(1, "alu register ops", n_alu, 70);
		run_test(2, "immediates and r0", n_imm, 60);
		run_test(3, "dependency chains", n_chain, 100);
		run_test(4, "branches", n_branch, 80);
		run_test(5, "jumps", n_jump, 100);
		run_test(6, "credits and order", n_credit, -1);
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
